// ==== flist.f ====
+incdir+.
fir_pkg.sv
fir_delay_line.sv
fir_coef_bank.sv
fir_mult_stage.sv
fir_adder_tree.sv
windowed_fir.sv
tb_windowed_fir.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_windowed_fir
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -Wno-fatal -j 0
PASS_MSG  ?= Done: no errors

SRCS := $(filter-out +%,$(shell cat $(FLIST))) fir_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_windowed_fir.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module tb_windowed_fir;

   import fir_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DLY    = 2;   // Inputs change this long after the rising edge
   localparam int RESET_CYCLES = 5;
   localparam int SETTLE       = `FIR_TAPS + `FIR_LATENCY;
   localparam int RANDOM_N     = 300;
   localparam int SWITCH_N     = 4;
   localparam int SWITCH_SEG   = 100;

   // Cycle budget of each test, used by the watchdog
   localparam int RESET_LEN   = RESET_CYCLES + 10;
   localparam int IMPULSE_LEN = `FIR_WINDOWS * (2 * SETTLE + 9);
   localparam int DC_LEN      = `FIR_WINDOWS * (SETTLE + 14);
   localparam int RANDOM_LEN  = `FIR_WINDOWS * RANDOM_N;
   localparam int SWITCH_LEN  = SWITCH_N * SWITCH_SEG;
   localparam int TOTAL_LEN   = RESET_LEN + IMPULSE_LEN + DC_LEN + RANDOM_LEN + SWITCH_LEN;
   localparam int MARGIN      = 200;

   logic        clk;
   logic        arst_n;
   sample_t     x_in;
   window_sel_t window_sel;
   sample_t     y;

   int          seed = 32'hf3ae;

   string       test_name;
   int          errors;
   int          err_at_start;
   int          tests_run;
   int          tests_failed;
   int          compared;
   logic        in_switch;     // Window switching test is running

   // Reference model state
   sample_t     hist [0:`FIR_TAPS-1];       // Halved history, index 0 newest
   sample_t     fold_prev [0:`FIR_FOLD-1];  // Folds of the previous edge
   sample_t     exp_q [$];                  // Values on their way to y
   sample_t     exp_y;                      // Expected y after the last edge

   window_sel_t win_prev;
   int          stable_cnt;
   logic        settled;
   int          rel_cnt;       // Edges since reset release
   sample_t     y_prev;
   int          same_run;      // Cycles y has kept its value

   windowed_fir i_windowed_fir (
      .clk        (clk),
      .arst_n     (arst_n),
      .x_in       (x_in),
      .window_sel (window_sel),
      .y          (y)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic string window_name(input window_sel_t w);
      case (w)
         3'd0: return "hann";
         3'd1: return "kaiser_hann";
         3'd2: return "hamming";
         3'd3: return "kaiser_hamming";
         3'd4: return "blackman";
         3'd5: return "blackman_kaiser";
         3'd6: return "rectangular";
         default: return "sparse_kaiser";
      endcase
   endfunction

   // One output sample from the stored folds and the given window
   function automatic sample_t filter_out(input window_sel_t w);
      product_t p;
      sample_t  t [0:`FIR_FOLD-1];
      int       n;
      for (int i = 0; i < `FIR_FOLD; i++) begin
         p    = product_t'(fold_prev[i]) * product_t'(FIR_COEF_TABLE[w].c[i]);
         t[i] = p[`FIR_PROD_W-2:`FIR_SAMPLE_W-1];  // Scaled slice
      end
      n = `FIR_FOLD;
      while (n > 1) begin
         for (int i = 0; i < n / 2; i++) begin
            t[i] = t[2*i] + t[2*i+1];  // Pairwise, wraps at 18 bits
         end
         n = n / 2;
      end
      return t[0];
   endfunction

   // Steady-state output for a constant input, every tap holds the same half
   function automatic sample_t dc_expected(input window_sel_t w, input sample_t level);
      sample_t  half;
      sample_t  f;
      product_t p;
      sample_t  acc;
      half = level >>> 1;
      acc  = '0;
      for (int i = 0; i < `FIR_FOLD; i++) begin
         f   = (i == `FIR_FOLD - 1) ? half : sample_t'(half + half);
         p   = product_t'(f) * product_t'(FIR_COEF_TABLE[w].c[i]);
         acc = acc + sample_t'(p[`FIR_PROD_W-2:`FIR_SAMPLE_W-1]);  // Modulo sum equals the tree
      end
      return acc;
   endfunction

   // Value pushed at edge m shows on y after edge m+5
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `FIR_TAPS; i++) begin
            hist[i] = '0;
         end
         for (int i = 0; i < `FIR_FOLD; i++) begin
            fold_prev[i] = '0;
         end
         exp_q.delete();
         for (int i = 0; i < `FIR_LATENCY - 1; i++) begin
            exp_q.push_back(sample_t'(0));
         end
         exp_y <= '0;
      end else begin
         exp_q.push_back(filter_out(window_sel));  // Select is taken one edge after the taps
         exp_y <= exp_q.pop_front();
         for (int i = `FIR_TAPS - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
         end
         hist[0] = x_in >>> 1;
         for (int i = 0; i < `FIR_FOLD - 1; i++) begin
            fold_prev[i] = hist[i] + hist[`FIR_TAPS-1-i];
         end
         fold_prev[`FIR_FOLD-1] = hist[`FIR_FOLD-1];
      end
   end

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         win_prev   <= '0;
         stable_cnt <= 0;
      end else begin
         win_prev <= window_sel;
         if (window_sel != win_prev) begin
            stable_cnt <= 0;
         end else if (stable_cnt < SETTLE) begin
            stable_cnt <= stable_cnt + 1;
         end
      end
   end

   assign settled = (stable_cnt >= SETTLE);

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rel_cnt <= 0;
      end else if (rel_cnt <= `FIR_LATENCY) begin
         rel_cnt <= rel_cnt + 1;
      end
   end

   always @(posedge clk) begin
      if (arst_n && settled) begin
         compared++;
      end
   end

   // Watched on the falling edge where y is stable
   always @(negedge clk) begin
      if (y == y_prev) begin
         same_run <= same_run + 1;
      end else begin
         same_run <= 0;
      end
      y_prev <= y;
   end

   reset_zero_a: assert property (
      @(posedge clk) (!arst_n || rel_cnt <= `FIR_LATENCY) |-> (y == '0)
   ) else begin
      errors++;
      $display("Error: %s expected 0 actual %0d", test_name, $sampled(y));
   end

   y_match_a: assert property (
      @(posedge clk) disable iff (!arst_n) settled |-> (y == exp_y)
   ) else begin
      errors++;
      $display("Error: %s expected %0d actual %0d", test_name, $sampled(exp_y),
               $sampled(y));
   end

   // Several samples in flight keep y moving while the new window fills in
   y_moving_a: assert property (
      @(posedge clk) disable iff (!arst_n) (in_switch && !settled) |-> (same_run < 4)
   ) else begin
      errors++;
      $display("%s: y stayed at %0d for %0d cycles during the window transient",
               test_name, $sampled(y), $sampled(same_run));
   end

   task automatic drive_sample(input sample_t x);
      @(posedge clk);
      #DRIVE_DLY;
      x_in = x;
   endtask

   task automatic begin_test(input string name);
      test_name    = name;
      err_at_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == err_at_start) begin
         $display("Test %-24s pass", test_name);
      end else begin
         tests_failed++;
         $display("Test %-24s FAIL with %0d errors", test_name, errors - err_at_start);
      end
   endtask

   task automatic run_impulse(input window_sel_t w);
      sample_t resp [0:`FIR_TAPS-1];
      begin_test($sformatf("impulse_%s", window_name(w)));
      drive_sample('0);
      window_sel = w;
      repeat (SETTLE + 3) drive_sample('0);  // Flush the previous history
      drive_sample(18'sd65536);
      for (int j = 0; j < SETTLE + 4; j++) begin
         drive_sample('0);
         if (j >= `FIR_LATENCY && j < SETTLE) begin
            resp[j - `FIR_LATENCY] = y;
         end
      end
      for (int n = 0; n < `FIR_FOLD - 1; n++) begin
         assert (resp[n] == resp[`FIR_TAPS-1-n]) else begin
            errors++;
            $display("Error: %s expected %0d actual %0d at output %0d", test_name,
                     resp[n], resp[`FIR_TAPS-1-n], `FIR_TAPS - 1 - n);
         end
      end
      assert (resp[`FIR_FOLD-1] != '0) else begin
         errors++;
         $display("%s: the center sample of the impulse response is zero", test_name);
      end
      end_test();
   endtask

   task automatic run_dc(input window_sel_t w);
      sample_t level;
      sample_t dc_exp;
      begin_test($sformatf("dc_step_%s", window_name(w)));
      level = w[0] ? -18'sd50000 : 18'sd40000;
      drive_sample(level);
      window_sel = w;
      repeat (SETTLE + 9) drive_sample(level);
      dc_exp = dc_expected(w, level);
      repeat (4) begin
         drive_sample(level);
         assert (y == dc_exp) else begin
            errors++;
            $display("Error: %s expected %0d actual %0d", test_name, dc_exp, y);
         end
      end
      end_test();
   endtask

   task automatic run_random(input window_sel_t w);
      int      r;
      int      t;
      int      k;
      sample_t x;
      begin_test($sformatf("random_%s", window_name(w)));
      for (int i = 0; i < RANDOM_N; i++) begin
         r = $random(seed);
         t = 80 - (i % 100);
         k = (t < `FIR_FOLD) ? t : `FIR_TAPS - 1 - t;
         if (i % 100 == 40 || i % 100 == 41) begin
            x = 18'sh20000;  // Negative full scale
         end else if (i % 100 == 20) begin
            x = 18'sh1ffff;
         end else if (t >= 0 && t < `FIR_TAPS) begin
            // Signs matched to the taps push the tree sum past 18 bits
            x = (FIR_COEF_TABLE[w].c[k] < 0) ? -18'sd131071 : 18'sd131071;
         end else begin
            x = r[17:0];
         end
         drive_sample(x);
         if (i == 0) begin
            window_sel = w;
         end
      end
      end_test();
   endtask

   task automatic run_switch();
      window_sel_t order [0:SWITCH_N-1];
      int          r;
      order[0] = 3'd2;
      order[1] = 3'd7;
      order[2] = 3'd0;
      order[3] = 3'd5;
      begin_test("window_switch");
      in_switch = 1'b1;
      for (int s = 0; s < SWITCH_N; s++) begin
         for (int i = 0; i < SWITCH_SEG; i++) begin
            r = $random(seed);
            drive_sample(r[17:0]);
            if (i == SWITCH_SEG / 2) begin
               window_sel = order[s];  // Mid-stream change
            end
         end
      end
      in_switch = 1'b0;
      end_test();
   endtask

   initial begin
      arst_n       = 1'b1;
      x_in         = '0;
      window_sel   = '0;
      in_switch    = 1'b0;
      errors       = 0;
      err_at_start = 0;
      tests_run    = 0;
      tests_failed = 0;
      compared     = 0;

      begin_test("reset");
      #1;
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      arst_n = 1'b1;
      repeat (10) drive_sample('0);
      end_test();

      for (int w = 0; w < `FIR_WINDOWS; w++) begin
         run_impulse(window_sel_t'(w));
      end
      for (int w = 0; w < `FIR_WINDOWS; w++) begin
         run_dc(window_sel_t'(w));
      end
      for (int w = 0; w < `FIR_WINDOWS; w++) begin
         run_random(window_sel_t'(w));
      end
      run_switch();

      $display("Summary: %0d tests, %0d failed, %0d cycles compared, %0d errors",
               tests_run, tests_failed, compared, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   initial begin
      #((TOTAL_LEN + MARGIN) * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d clock cycles",
               TOTAL_LEN + MARGIN);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== windowed_fir.sv ====
`timescale 1ns/1ps
`default_nettype none

module windowed_fir (
   input  logic                 clk,
   input  logic                 arst_n,
   input  fir_pkg::sample_t     x_in,
   input  fir_pkg::window_sel_t window_sel,
   output fir_pkg::sample_t     y
);

   import fir_pkg::*;

   fold_bus_t fold;   // Registered folded sums
   coef_set_t coefs;  // Active window
   term_bus_t terms;  // Registered scaled products

   fir_delay_line i_fir_delay_line (
      .clk    (clk),
      .arst_n (arst_n),
      .x_in   (x_in),
      .fold   (fold)
   );

   fir_coef_bank i_fir_coef_bank (
      .clk        (clk),
      .arst_n     (arst_n),
      .window_sel (window_sel),
      .coefs      (coefs)
   );

   fir_mult_stage i_fir_mult_stage (
      .clk    (clk),
      .arst_n (arst_n),
      .fold   (fold),
      .coefs  (coefs),
      .terms  (terms)
   );

   // Four levels, y is the last register
   fir_adder_tree i_fir_adder_tree (
      .clk    (clk),
      .arst_n (arst_n),
      .terms  (terms),
      .y      (y)
   );

endmodule

`default_nettype wire

// ==== fir_adder_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module fir_adder_tree (
   input  logic               clk,
   input  logic               arst_n,
   input  fir_pkg::term_bus_t terms,
   output fir_pkg::sample_t   y
);

   import fir_pkg::*;

   localparam int L1_N = `FIR_FOLD / 2;  // 8 sums
   localparam int L2_N = L1_N / 2;       // 4 sums
   localparam int L3_N = L2_N / 2;       // 2 sums

   sample_t lvl1 [0:L1_N-1];
   sample_t lvl2 [0:L2_N-1];
   sample_t lvl3 [0:L3_N-1];

   // Pairwise sums, each level wraps at 18 bits
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < L1_N; i++) begin
            lvl1[i] <= '0;
         end
         for (int i = 0; i < L2_N; i++) begin
            lvl2[i] <= '0;
         end
         for (int i = 0; i < L3_N; i++) begin
            lvl3[i] <= '0;
         end
         y <= '0;
      end else begin
         for (int i = 0; i < L1_N; i++) begin
            lvl1[i] <= terms.t[2*i] + terms.t[2*i+1];
         end
         for (int i = 0; i < L2_N; i++) begin
            lvl2[i] <= lvl1[2*i] + lvl1[2*i+1];
         end
         for (int i = 0; i < L3_N; i++) begin
            lvl3[i] <= lvl2[2*i] + lvl2[2*i+1];
         end
         y <= lvl3[0] + lvl3[1];  // Final level is the output
      end
   end

   // An X here means an unknown coefficient or tap upstream
   y_known_a: assert property (
      @(posedge clk) disable iff (!arst_n) !$isunknown(y)
   ) else $error("fir_adder_tree: y is unknown");

endmodule

`default_nettype wire

// ==== fir_mult_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module fir_mult_stage (
   input  logic               clk,
   input  logic               arst_n,
   input  fir_pkg::fold_bus_t fold,
   input  fir_pkg::coef_set_t coefs,
   output fir_pkg::term_bus_t terms
);

   import fir_pkg::*;

   product_t  prod [0:`FIR_FOLD-1];  // Full-width products
   term_bus_t terms_d;

   always_comb begin
      for (int i = 0; i < `FIR_FOLD; i++) begin
         prod[i] = fold.sum[i] * coefs.c[i];  // Signed 18x18
      end
   end

   // Drop the redundant sign bit and the Q1.16 fraction
   always_comb begin
      for (int i = 0; i < `FIR_FOLD; i++) begin
         terms_d.t[i] = prod[i][`FIR_SLICE_HI:`FIR_SLICE_LO];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         terms <= '0;
      end else begin
         terms <= terms_d;  // Multiplies get a full cycle
      end
   end

endmodule

`default_nettype wire

// ==== fir_coef_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module fir_coef_bank (
   input  logic                 clk,
   input  logic                 arst_n,
   input  fir_pkg::window_sel_t window_sel,
   output fir_pkg::coef_set_t   coefs
);

   import fir_pkg::*;

   window_sel_t sel_q;  // Select aligned to the clock

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sel_q <= '0;  // Hann after reset
      end else begin
         sel_q <= window_sel;
      end
   end

   assign coefs = FIR_COEF_TABLE[sel_q];  // Row lookup from the package table

   // Every window must pass the center tap, otherwise the gain collapses
   center_coef_a: assert property (
      @(posedge clk) disable iff (!arst_n) coefs.c[`FIR_FOLD-1] != '0
   ) else $error("fir_coef_bank: zero center coefficient for window %0d", sel_q);

endmodule

`default_nettype wire

// ==== fir_delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module fir_delay_line (
   input  logic             clk,
   input  logic             arst_n,
   input  fir_pkg::sample_t x_in,
   output fir_pkg::fold_bus_t fold
);

   import fir_pkg::*;

   sample_t                  half_in;  // Input scaled by one half
   sample_t [0:`FIR_TAPS-1]  taps;     // Tap 0 is the newest sample
   fold_bus_t                fold_d;

   assign half_in = x_in >>> 1;  // Arithmetic shift keeps the sign

   // Shift register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         taps <= '0;
      end else begin
         taps[0] <= half_in;
         for (int i = 1; i < `FIR_TAPS; i++) begin
            taps[i] <= taps[i-1];
         end
      end
   end

   // Symmetric pre-add, one sum per mirrored tap pair
   always_comb begin
      for (int i = 0; i < `FIR_FOLD - 1; i++) begin
         fold_d.sum[i] = taps[i] + taps[`FIR_TAPS-1-i];  // Wraps at 18 bits
      end
      fold_d.sum[`FIR_FOLD-1] = taps[`FIR_FOLD-1];       // Center tap alone
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fold <= '0;
      end else begin
         fold <= fold_d;
      end
   end

   // Any X on x_in spreads through every later stage
   taps_known_a: assert property (
      @(posedge clk) disable iff (!arst_n) !$isunknown(taps)
   ) else $error("fir_delay_line: unknown value in tap register");

endmodule

`default_nettype wire

// ==== fir_pkg.sv ====
`default_nettype none

`include "fir_defines.svh"

package fir_pkg;

   typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;   // Sample, term or sum
   typedef logic signed [`FIR_COEF_W-1:0]   coef_t;     // Q1.16 coefficient
   typedef logic signed [`FIR_PROD_W-1:0]   product_t;  // Full signed product
   typedef logic        [`FIR_WIN_W-1:0]    window_sel_t;

   // Folded sums, index 15 is the center tap
   typedef struct packed {
      sample_t [0:`FIR_FOLD-1] sum;
   } fold_bus_t;

   // One coefficient per folded sum
   typedef struct packed {
      coef_t [0:`FIR_FOLD-1] c;
   } coef_set_t;

   // Scaled products ready for the adder tree
   typedef struct packed {
      sample_t [0:`FIR_FOLD-1] t;
   } term_bus_t;

   // Coefficient sets indexed by window_sel
   // Row entries run from the outer tap pair to the center tap
   localparam coef_set_t FIR_COEF_TABLE [0:`FIR_WINDOWS-1] = '{
      // Hann
      '{'{0, -65, -195, 0, 881, 2071, 2249, 0, -4621, -9036, -8786, 0,
          17661, 39628, 57935, 65060}},
      // Kaiser-Hann
      '{'{-391, -912, -976, 0, 1929, 3663, 3413, 0, -5746, -10519, -9726, 0,
          18305, 40303, 58276, 65207}},
      // Hamming
      '{'{-313, -535, -542, 0, 1241, 2577, 2598, 0, -4938, -9451, -9052, 0,
          17872, 39911, 58189, 65288}},
      // Kaiser-Hamming
      '{'{-163, -474, -585, 0, 1393, 2831, 2790, 0, -5119, -9683, -9195, 0,
          17969, 40019, 58260, 65336}},
      // Blackman
      '{'{0, -24, -76, 0, 413, 1083, 1315, 0, -3317, -7081, -7425, 0,
          16682, 38765, 57878, 65455}},
      // Blackman-Kaiser
      '{'{-22, -114, -193, 0, 689, 1619, 1801, 0, -3979, -8076, -8125, 0,
          17221, 39313, 58080, 65453}},
      // Rectangular
      '{'{-3568, -5407, -4117, 0, 4866, 7570, 5947, 0, -7647, -12616, -10705, 0,
          17842, 37849, 53527, 59453}},
      // Sparse Kaiser, odd taps are zero
      '{'{0, 0, 0, 0, -410, 0, 1234, 0, -2822, 0, 5791, 0,
          -12234, 0, 41139, 65536}}
   };

endpackage

`default_nettype wire

// ==== fir_defines.svh ====
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// Filter geometry
`define FIR_TAPS       31                   // Delay-line length
`define FIR_FOLD       16                   // Folded sums after symmetric pre-add

// Datapath widths
`define FIR_SAMPLE_W   18                   // Sample, term and sum width
`define FIR_COEF_W     18                   // Coefficient width in Q1.16
`define FIR_PROD_W     36                   // Full multiplier width

// Scaled product slice taken from each multiply
`define FIR_SLICE_HI   (`FIR_PROD_W - 2)    // Bit 34
`define FIR_SLICE_LO   (`FIR_SAMPLE_W - 1)  // Bit 17

// Window select
`define FIR_WIN_W      3                    // Select width
`define FIR_WINDOWS    8                    // Number of built-in windows

// Clock edges from x_in sampled to y updated
// Delay line 1, fold 1, multiply 1, adder tree 4 minus the tap edge
`define FIR_LATENCY    6

`endif
